//--- design/car_consts.svh
`ifndef CAR_CONSTS_SVH
`define CAR_CONSTS_SVH

// One NEC unit of 562.5 us at 50 MHz
`define IR_UNIT_CYCLES 28125

`define PWM_PERIOD 16

// High cycles per PWM period
`define DUTY_SLOW   4
`define DUTY_MEDIUM 8
`define DUTY_FAST   16

`endif

//--- design/remote_pkg.sv
package remote_pkg;

    typedef logic [7:0] key_code_t;     // NEC command byte

    // Mode keys
    localparam key_code_t KEY_CAM      = 8'h0F;
    localparam key_code_t KEY_IR       = 8'h13;
    localparam key_code_t KEY_IDLE     = 8'h10;

    localparam key_code_t KEY_STOP     = 8'h0C;
    localparam key_code_t KEY_LEFT     = 8'h07;
    localparam key_code_t KEY_RIGHT    = 8'h09;
    localparam key_code_t KEY_FAST     = 8'h02;
    localparam key_code_t KEY_MEDIUM   = 8'h05;
    localparam key_code_t KEY_SLOW     = 8'h08;
    localparam key_code_t KEY_REVERSE  = 8'h00;
    localparam key_code_t KEY_LREVERSE = 8'h11;
    localparam key_code_t KEY_RREVERSE = 8'h18;

    typedef struct packed {
        logic [7:0] cmd_inv;            // Last byte on air
        key_code_t  cmd;
        logic [7:0] addr_inv;
        logic [7:0] addr;               // First byte on air
    } ir_fields_t;

    typedef union packed {
        logic [31:0] raw;
        ir_fields_t  fields;
    } ir_frame_u;

endpackage

//--- design/drive_pkg.sv
package drive_pkg;

    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_CAM  = 2'd1,
        MODE_IR   = 2'd2
    } run_mode_t;

    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FOLLOW = 2'd1,
        PAUSE  = 2'd3                   // Outside camera mode
    } track_state_t;

    typedef enum logic [3:0] {
        STOP     = 4'd0,
        LEFT     = 4'd1,
        RIGHT    = 4'd2,
        SLOW     = 4'd3,
        MEDIUM   = 4'd4,
        FAST     = 4'd5,
        REVERSE  = 4'd6,
        LREVERSE = 4'd7,
        RREVERSE = 4'd8
    } drive_cmd_t;

endpackage

//--- design/ir_nec_receiver.sv
`timescale 1ns/1ps
`include "car_consts.svh"

module ir_nec_receiver #(
    parameter int unit_cycles = `IR_UNIT_CYCLES
) (
    input  logic                  clk_50,
    input  logic                  reset,
    input  logic                  ir_rx,
    input  logic                  key_ack,
    output logic                  key_req,
    output remote_pkg::key_code_t key_code
);
    import remote_pkg::*;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_LEAD_LOW,
        RX_LEAD_HIGH,
        RX_BIT_LOW,
        RX_BIT_HIGH
    } rx_state_t;

    localparam int DIV_W = $clog2(unit_cycles + 1);

    rx_state_t        rx_state;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       width;            // Whole units since last edge
    logic             ir_prev;
    logic [5:0]       bit_cnt;
    ir_frame_u        frame;
    logic             frame_done;
    logic             fall_edge;
    logic             rise_edge;
    logic             load_key;

    assign fall_edge = ir_prev & ~ir_rx;
    assign rise_edge = ~ir_prev & ir_rx;
    assign load_key  = frame_done && !key_req && !key_ack &&
                       (frame.fields.cmd == ~frame.fields.cmd_inv) &&
                       (frame.fields.addr == ~frame.fields.addr_inv);

    always_ff @(posedge clk_50) begin
        if (reset) begin
            ir_prev <= 1'b1;
            div_cnt <= '0;
            width   <= '0;
        end else begin
            ir_prev <= ir_rx;
            if (fall_edge || rise_edge) begin
                div_cnt <= '0;
                width   <= '0;
            end else if (div_cnt == DIV_W'(unit_cycles - 1)) begin
                div_cnt <= '0;
                if (width != 5'h1F)
                    width <= width + 5'd1;  // Saturates
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            rx_state   <= RX_IDLE;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    if (fall_edge)
                        rx_state <= RX_LEAD_LOW;
                end
                RX_LEAD_LOW: begin
                    if (rise_edge)
                        rx_state <= (width >= 5'd12) ? RX_LEAD_HIGH : RX_IDLE;
                end
                RX_LEAD_HIGH: begin
                    if (fall_edge) begin
                        rx_state <= (width >= 5'd6) ? RX_BIT_LOW : RX_LEAD_LOW;
                        bit_cnt  <= '0;
                    end
                end
                RX_BIT_LOW: begin
                    if (rise_edge && bit_cnt == 6'd32) begin
                        rx_state   <= RX_IDLE;  // Stop burst done
                        frame_done <= 1'b1;
                    end else if (rise_edge) begin
                        rx_state <= RX_BIT_HIGH;
                    end else if (width > 5'd2) begin
                        rx_state <= RX_IDLE;    // Burst too long
                    end
                end
                RX_BIT_HIGH: begin
                    if (fall_edge) begin
                        bit_cnt  <= bit_cnt + 6'd1;
                        rx_state <= RX_BIT_LOW;
                    end else if (width > 5'd4) begin
                        rx_state <= RX_IDLE;    // Lost the frame
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    // Long space is a 1, bits arrive LSB first
    always_ff @(posedge clk_50) begin
        if (rx_state == RX_BIT_HIGH && fall_edge)
            frame.raw <= {(width >= 5'd2), frame.raw[31:1]};
    end

    always_ff @(posedge clk_50) begin
        if (reset)
            key_req <= 1'b0;
        else if (key_req && key_ack)
            key_req <= 1'b0;
        else if (load_key)
            key_req <= 1'b1;
    end

    always_ff @(posedge clk_50) begin
        if (load_key)
            key_code <= frame.fields.cmd;
    end

endmodule

//--- design/mode_controller.sv
`timescale 1ns/1ps

module mode_controller (
    input  logic                    clk_50,
    input  logic                    reset,
    input  logic                    key_req,
    input  remote_pkg::key_code_t   key_code,
    input  logic [2:0]              cam_direction,
    input  logic [1:0]              speed,
    input  logic                    orange_detected,
    output logic                    key_ack,
    output drive_pkg::run_mode_t    mode,
    output drive_pkg::track_state_t track_state,
    output drive_pkg::drive_cmd_t   drive_cmd,
    output logic                    mode_changed
);
    import remote_pkg::*;
    import drive_pkg::*;

    run_mode_t    next_mode;
    track_state_t next_track;
    drive_cmd_t   next_drive;
    drive_cmd_t   manual_cmd;
    drive_cmd_t   next_manual;
    logic         key_event;

    assign key_event = key_req && !key_ack;     // First cycle of a request

    always_comb begin
        next_mode = mode;
        if (key_event) begin
            case (mode)
                MODE_IDLE: begin
                    if (key_code == KEY_CAM)
                        next_mode = MODE_CAM;
                    else if (key_code == KEY_IR)
                        next_mode = MODE_IR;
                end
                MODE_CAM: begin
                    if (key_code == KEY_IR)
                        next_mode = MODE_IR;
                    else if (key_code == KEY_IDLE)
                        next_mode = MODE_IDLE;
                end
                MODE_IR: begin
                    if (key_code == KEY_CAM)
                        next_mode = MODE_CAM;
                    else if (key_code == KEY_IDLE)
                        next_mode = MODE_IDLE;
                end
                default: next_mode = MODE_IDLE;
            endcase
        end
    end

    always_comb begin
        if (next_mode != MODE_CAM)
            next_track = PAUSE;
        else if (track_state == PAUSE)
            next_track = SEARCH;            // Entering camera mode
        else
            next_track = orange_detected ? FOLLOW : SEARCH;
    end

    always_comb begin
        next_manual = manual_cmd;
        if (mode != MODE_IR) begin
            next_manual = STOP;             // Starts from STOP in IR mode
        end else if (key_event) begin
            case (key_code)
                KEY_STOP:     next_manual = STOP;
                KEY_LEFT:     next_manual = LEFT;
                KEY_RIGHT:    next_manual = RIGHT;
                KEY_FAST:     next_manual = FAST;
                KEY_MEDIUM:   next_manual = MEDIUM;
                KEY_SLOW:     next_manual = SLOW;
                KEY_REVERSE:  next_manual = REVERSE;
                KEY_LREVERSE: next_manual = LREVERSE;
                KEY_RREVERSE: next_manual = RREVERSE;
                default:      next_manual = manual_cmd;
            endcase
        end
    end

    always_comb begin
        next_drive = STOP;
        if (speed != 2'b11) begin
            if (next_mode == MODE_CAM) begin
                if (cam_direction == 3'b010)
                    next_drive = RIGHT;
                else if (cam_direction == 3'b001)
                    next_drive = LEFT;
                else if (next_track == FOLLOW && cam_direction == 3'b011)
                    next_drive = (speed == 2'b00) ? SLOW :
                                 (speed == 2'b01) ? MEDIUM : FAST;
            end else if (next_mode == MODE_IR) begin
                if (orange_detected && cam_direction == 3'b010)
                    next_drive = LEFT;      // Steer away from obstacle
                else if (orange_detected && cam_direction == 3'b001)
                    next_drive = RIGHT;
                else
                    next_drive = next_manual;
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            key_ack      <= 1'b0;
            mode         <= MODE_IDLE;
            track_state  <= PAUSE;
            drive_cmd    <= STOP;
            manual_cmd   <= STOP;
            mode_changed <= 1'b0;
        end else begin
            key_ack      <= key_req;
            mode         <= next_mode;
            track_state  <= next_track;
            drive_cmd    <= next_drive;
            manual_cmd   <= next_manual;
            mode_changed <= (next_mode != mode) || (next_track != track_state);
        end
    end

endmodule

//--- design/motor_pwm.sv
`timescale 1ns/1ps
`include "car_consts.svh"

module motor_pwm (
    input  logic                  clk_50,
    input  logic                  reset,
    input  drive_pkg::drive_cmd_t drive_cmd,
    input  logic                  mode_changed,
    output logic                  motor_left_pwm,
    output logic                  motor_right_pwm,
    output logic                  motor_left_rev,
    output logic                  motor_right_rev
);
    import drive_pkg::*;

    localparam int CNT_W  = $clog2(`PWM_PERIOD);
    localparam int DUTY_W = $clog2(`PWM_PERIOD + 1);

    logic [CNT_W-1:0]  period_cnt;
    logic [DUTY_W-1:0] left_duty;
    logic [DUTY_W-1:0] right_duty;
    logic              left_rev;
    logic              right_rev;

    always_comb begin
        left_duty  = '0;
        right_duty = '0;
        left_rev   = 1'b0;
        right_rev  = 1'b0;
        case (drive_cmd)
            LEFT:     right_duty = DUTY_W'(`DUTY_MEDIUM);
            RIGHT:    left_duty  = DUTY_W'(`DUTY_MEDIUM);
            SLOW: begin
                left_duty  = DUTY_W'(`DUTY_SLOW);
                right_duty = DUTY_W'(`DUTY_SLOW);
            end
            MEDIUM: begin
                left_duty  = DUTY_W'(`DUTY_MEDIUM);
                right_duty = DUTY_W'(`DUTY_MEDIUM);
            end
            FAST: begin
                left_duty  = DUTY_W'(`DUTY_FAST);
                right_duty = DUTY_W'(`DUTY_FAST);
            end
            REVERSE: begin
                left_duty  = DUTY_W'(`DUTY_MEDIUM);
                right_duty = DUTY_W'(`DUTY_MEDIUM);
                left_rev   = 1'b1;
                right_rev  = 1'b1;
            end
            LREVERSE: begin
                right_duty = DUTY_W'(`DUTY_MEDIUM);
                right_rev  = 1'b1;
            end
            RREVERSE: begin
                left_duty  = DUTY_W'(`DUTY_MEDIUM);
                left_rev   = 1'b1;
            end
            default: left_rev = 1'b0;       // STOP
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (reset)
            period_cnt <= '0;
        else if (mode_changed || period_cnt == CNT_W'(`PWM_PERIOD - 1))
            period_cnt <= '0;               // Realign on state change
        else
            period_cnt <= period_cnt + 1'b1;
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            motor_left_pwm  <= 1'b0;
            motor_right_pwm <= 1'b0;
            motor_left_rev  <= 1'b0;
            motor_right_rev <= 1'b0;
        end else begin
            motor_left_pwm  <= DUTY_W'(period_cnt) < left_duty;
            motor_right_pwm <= DUTY_W'(period_cnt) < right_duty;
            motor_left_rev  <= left_rev;
            motor_right_rev <= right_rev;
        end
    end

endmodule

//--- design/status_display.sv
`timescale 1ns/1ps

module status_display (
    input  drive_pkg::run_mode_t    mode,
    input  drive_pkg::track_state_t track_state,
    input  drive_pkg::drive_cmd_t   drive_cmd,
    output logic [6:0]              hex0,
    output logic [6:0]              hex1,
    output logic [6:0]              hex2,
    output logic [6:0]              hex3,
    output logic [6:0]              hex4,
    output logic [6:0]              hex5,
    output logic [6:0]              hex6,
    output logic [6:0]              hex7
);
    import drive_pkg::*;

    // Active low with segment g in bit 6
    localparam logic [6:0] SEG_BLANK = 7'b1111111;
    localparam logic [6:0] SEG_A     = 7'b0001000;
    localparam logic [6:0] SEG_C     = 7'b1000110;
    localparam logic [6:0] SEG_D     = 7'b0100001;
    localparam logic [6:0] SEG_E     = 7'b0000110;
    localparam logic [6:0] SEG_F     = 7'b0001110;
    localparam logic [6:0] SEG_G     = 7'b0000010;
    localparam logic [6:0] SEG_H     = 7'b0001001;
    localparam logic [6:0] SEG_I     = 7'b1111001;
    localparam logic [6:0] SEG_L     = 7'b1000111;
    localparam logic [6:0] SEG_O     = 7'b1000000;
    localparam logic [6:0] SEG_P     = 7'b0001100;
    localparam logic [6:0] SEG_R     = 7'b0101111;
    localparam logic [6:0] SEG_S     = 7'b0010010;
    localparam logic [6:0] SEG_T     = 7'b0000111;
    localparam logic [6:0] SEG_1     = 7'b1111001;
    localparam logic [6:0] SEG_2     = 7'b0100100;
    localparam logic [6:0] SEG_3     = 7'b0110000;

    assign hex5 = SEG_BLANK;

    always_comb begin
        case (mode)
            MODE_CAM: {hex7, hex6} = {SEG_C, SEG_A};
            MODE_IR:  {hex7, hex6} = {SEG_I, SEG_R};
            default:  {hex7, hex6} = {SEG_I, SEG_D};
        endcase
    end

    always_comb begin
        case (track_state)
            SEARCH:  hex4 = SEG_S;
            FOLLOW:  hex4 = SEG_F;
            PAUSE:   hex4 = SEG_P;
            default: hex4 = SEG_BLANK;
        endcase
    end

    always_comb begin
        case (drive_cmd)
            STOP:    {hex3, hex2, hex1, hex0} = {SEG_S, SEG_T, SEG_O, SEG_P};
            LEFT:    {hex3, hex2, hex1, hex0} = {SEG_L, SEG_E, SEG_F, SEG_T};
            RIGHT:   {hex3, hex2, hex1, hex0} = {SEG_R, SEG_G, SEG_H, SEG_T};
            SLOW:    {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_1};
            MEDIUM:  {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_2};
            FAST:    {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_3};
            default: {hex3, hex2, hex1, hex0} = {4{SEG_BLANK}};   // Reverse moves
        endcase
    end

endmodule

//--- design/car_top.sv
`timescale 1ns/1ps
`include "car_consts.svh"

module car_top #(
    parameter int unit_cycles = `IR_UNIT_CYCLES
) (
    input  logic                    clk_50,
    input  logic                    reset,
    input  logic                    ir_rx,
    input  logic [2:0]              cam_direction,
    input  logic [1:0]              speed,
    input  logic                    orange_detected,
    output drive_pkg::run_mode_t    mode,
    output drive_pkg::track_state_t track_state,
    output drive_pkg::drive_cmd_t   drive_cmd,
    output logic                    motor_left_pwm,
    output logic                    motor_right_pwm,
    output logic                    motor_left_rev,
    output logic                    motor_right_rev,
    output logic [6:0]              hex0,
    output logic [6:0]              hex1,
    output logic [6:0]              hex2,
    output logic [6:0]              hex3,
    output logic [6:0]              hex4,
    output logic [6:0]              hex5,
    output logic [6:0]              hex6,
    output logic [6:0]              hex7
);
    import remote_pkg::*;

    logic      key_req;
    logic      key_ack;
    key_code_t key_code;
    logic      mode_changed;

    ir_nec_receiver #(
        .unit_cycles(unit_cycles)
    ) u_receiver (
        .clk_50   (clk_50),
        .reset    (reset),
        .ir_rx    (ir_rx),
        .key_ack  (key_ack),
        .key_req  (key_req),
        .key_code (key_code)
    );

    mode_controller u_controller (
        .clk_50          (clk_50),
        .reset           (reset),
        .key_req         (key_req),
        .key_code        (key_code),
        .cam_direction   (cam_direction),
        .speed           (speed),
        .orange_detected (orange_detected),
        .key_ack         (key_ack),
        .mode            (mode),
        .track_state     (track_state),
        .drive_cmd       (drive_cmd),
        .mode_changed    (mode_changed)
    );

    motor_pwm u_motor (
        .clk_50          (clk_50),
        .reset           (reset),
        .drive_cmd       (drive_cmd),
        .mode_changed    (mode_changed),
        .motor_left_pwm  (motor_left_pwm),
        .motor_right_pwm (motor_right_pwm),
        .motor_left_rev  (motor_left_rev),
        .motor_right_rev (motor_right_rev)
    );

    status_display u_display (
        .mode        (mode),
        .track_state (track_state),
        .drive_cmd   (drive_cmd),
        .hex0        (hex0),
        .hex1        (hex1),
        .hex2        (hex2),
        .hex3        (hex3),
        .hex4        (hex4),
        .hex5        (hex5),
        .hex6        (hex6),
        .hex7        (hex7)
    );

endmodule

//--- bench/car_tb.sv
`timescale 1ns/1ps
`include "car_consts.svh"

module car_tb;
    import drive_pkg::*;

    localparam int UNIT_CYCLES   = 4;
    localparam int CLK_PERIOD_NS = 4;
    localparam int ACK_LIMIT     = 40;     // Cycles from stop bit to key_ack

    typedef struct packed {
        logic [7:0] key;
        logic       corrupt;
        logic [2:0] dir;
        logic [1:0] speed;
        logic       orange;
        logic [1:0] mode;
        logic [1:0] track;
        logic [3:0] drive;
        logic [6:0] hex7;
        logic [6:0] hex4;
    } record_t;

    logic         clk_50 = 1'b0;
    logic         reset;
    logic         ir_rx;
    logic [2:0]   cam_direction;
    logic [1:0]   speed;
    logic         orange_detected;
    run_mode_t    mode;
    track_state_t track_state;
    drive_cmd_t   drive_cmd;
    logic         motor_left_pwm;
    logic         motor_right_pwm;
    logic         motor_left_rev;
    logic         motor_right_rev;
    logic [6:0]   hex0;
    logic [6:0]   hex1;
    logic [6:0]   hex2;
    logic [6:0]   hex3;
    logic [6:0]   hex4;
    logic [6:0]   hex5;
    logic [6:0]   hex6;
    logic [6:0]   hex7;

    record_t records[$];
    int      num_records = 0;
    integer  seed;

    car_top #(
        .unit_cycles(UNIT_CYCLES)
    ) DUT (
        .clk_50          (clk_50),
        .reset           (reset),
        .ir_rx           (ir_rx),
        .cam_direction   (cam_direction),
        .speed           (speed),
        .orange_detected (orange_detected),
        .mode            (mode),
        .track_state     (track_state),
        .drive_cmd       (drive_cmd),
        .motor_left_pwm  (motor_left_pwm),
        .motor_right_pwm (motor_right_pwm),
        .motor_left_rev  (motor_left_rev),
        .motor_right_rev (motor_right_rev),
        .hex0            (hex0),
        .hex1            (hex1),
        .hex2            (hex2),
        .hex3            (hex3),
        .hex4            (hex4),
        .hex5            (hex5),
        .hex6            (hex6),
        .hex7            (hex7)
    );

    always #2 clk_50 = ~clk_50;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk_50);
        #0.5;                               // Drive and sample away from the edge
    endtask

    function automatic int duty_for_command(input drive_cmd_t cmd, input bit left_wheel);
        case (cmd)
            LEFT:            return left_wheel ? 0 : `DUTY_MEDIUM;
            RIGHT:           return left_wheel ? `DUTY_MEDIUM : 0;
            SLOW:            return `DUTY_SLOW;
            MEDIUM, REVERSE: return `DUTY_MEDIUM;
            FAST:            return `DUTY_FAST;
            LREVERSE:        return left_wheel ? 0 : `DUTY_MEDIUM;
            RREVERSE:        return left_wheel ? `DUTY_MEDIUM : 0;
            default:         return 0;
        endcase
    endfunction

    function automatic logic rev_for_command(input drive_cmd_t cmd, input bit left_wheel);
        return (cmd == REVERSE) || (cmd == LREVERSE && !left_wheel) ||
               (cmd == RREVERSE && left_wheel);
    endfunction

    // Active low letters with segment g in bit 6
    function automatic logic [6:0] mode_second_letter(input run_mode_t m);
        case (m)
            MODE_CAM: return 7'h08;         // A
            MODE_IR:  return 7'h2F;         // r
            default:  return 7'h21;         // d
        endcase
    endfunction

    function automatic logic [27:0] command_letters(input drive_cmd_t cmd);
        case (cmd)
            STOP:    return {7'h12, 7'h07, 7'h40, 7'h0C};
            LEFT:    return {7'h47, 7'h06, 7'h0E, 7'h07};
            RIGHT:   return {7'h2F, 7'h02, 7'h09, 7'h07};
            SLOW:    return {7'h12, 7'h0C, 7'h7F, 7'h79};
            MEDIUM:  return {7'h12, 7'h0C, 7'h7F, 7'h24};
            FAST:    return {7'h12, 7'h0C, 7'h7F, 7'h30};
            default: return {4{7'h7F}};
        endcase
    endfunction

    task automatic check_mode(input run_mode_t expected, input run_mode_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("Error: time %0.1f ns, mode expected %0d, got %0d",
                                        $realtime, expected, actual));
    endtask

    task automatic check_track(input track_state_t expected, input track_state_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("Error: time %0.1f ns, track_state expected %0d, got %0d",
                                        $realtime, expected, actual));
    endtask

    task automatic check_drive(input drive_cmd_t expected, input drive_cmd_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("Error: time %0.1f ns, drive_cmd expected %0d, got %0d",
                                        $realtime, expected, actual));
    endtask

    task automatic check_hex(input string name, input logic [6:0] expected,
                             input logic [6:0] actual);
        if (actual !== expected)
            stop_with_failure($sformatf("Error: time %0.1f ns, %s expected %h, got %h",
                                        $realtime, name, expected, actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            stop_with_failure($sformatf("Error: time %0.1f ns, %s expected %b, got %b",
                                        $realtime, name, expected, actual));
    endtask

    task automatic check_duty(input int left_expected, input int right_expected);
        int left_high;
        int right_high;
        left_high  = 0;
        right_high = 0;
        repeat (4) next_cycle();            // PWM period realigns after mode_changed
        repeat (`PWM_PERIOD) begin
            next_cycle();
            left_high  += (motor_left_pwm === 1'b1);
            right_high += (motor_right_pwm === 1'b1);
        end
        if (left_high != left_expected)
            stop_with_failure($sformatf("Error: time %0.1f ns, motor_left_pwm expected %0d, got %0d",
                                        $realtime, left_expected, left_high));
        if (right_high != right_expected)
            stop_with_failure($sformatf("Error: time %0.1f ns, motor_right_pwm expected %0d, got %0d",
                                        $realtime, right_expected, right_high));
    endtask

    task automatic hold_ir(input logic level, input int units);
        ir_rx = level;
        repeat (units * UNIT_CYCLES) next_cycle();
    endtask

    // NEC frame sent LSB first from the address byte
    task automatic send_frame(input logic [7:0] key, input logic corrupt);
        logic [31:0] word;
        word = {~key, key, 8'hFF, 8'h00};
        if (corrupt)
            word[24] = ~word[24];
        hold_ir(1'b0, 16);
        hold_ir(1'b1, 8);
        for (int i = 0; i < 32; i++) begin
            hold_ir(1'b0, 1);
            hold_ir(1'b1, word[i] ? 3 : 1);
        end
        hold_ir(1'b0, 1);                   // Stop burst
        ir_rx = 1'b1;
    endtask

    task automatic wait_for_ack();
        int waited;
        waited = 0;
        while (DUT.key_ack !== 1'b1) begin
            if (waited == ACK_LIMIT)
                stop_with_failure("The DUT gave no key_ack after a valid frame");
            next_cycle();
            waited++;
        end
    endtask

    task automatic expect_no_ack(input int cycles);
        repeat (cycles) begin
            next_cycle();
            if (DUT.key_ack === 1'b1)
                stop_with_failure("The DUT accepted a key from a corrupted frame");
        end
    endtask

    task automatic load_records();
        int    fd;
        int    n;
        string line;
        record_t r;
        int    key, corrupt, dir, spd, org, md, trk, drv, h7, h4;
        fd = $fopen("bench/car_testdata.txt", "r");
        if (fd == 0)
            stop_with_failure("Could not open bench/car_testdata.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", key, corrupt, dir, spd,
                            org, md, trk, drv, h7, h4) == 10) begin
                    r = {key[7:0], corrupt[0], dir[2:0], spd[1:0], org[0], md[1:0],
                         trk[1:0], drv[3:0], h7[6:0], h4[6:0]};
                    records.push_back(r);
                end
            end
        end
        $fclose(fd);
        if (records.size() == 0)
            stop_with_failure("The test data file holds no records");
        num_records = records.size();
    endtask

    task automatic run_record(input record_t r);
        int          gap;
        drive_cmd_t  exp_drive;
        logic [27:0] exp_letters;
        exp_drive       = drive_cmd_t'(r.drive);
        exp_letters     = command_letters(exp_drive);
        cam_direction   = r.dir;
        speed           = r.speed;
        orange_detected = r.orange;
        gap = 20 + ($unsigned($random(seed)) % 64);
        hold_ir(1'b1, gap);
        send_frame(r.key, r.corrupt);
        if (r.corrupt)
            expect_no_ack(200 * UNIT_CYCLES);
        else
            wait_for_ack();
        repeat (2) next_cycle();
        check_mode(run_mode_t'(r.mode), mode);
        check_track(track_state_t'(r.track), track_state);
        check_drive(exp_drive, drive_cmd);
        check_hex("hex7", r.hex7, hex7);
        check_hex("hex6", mode_second_letter(run_mode_t'(r.mode)), hex6);
        check_hex("hex5", 7'h7F, hex5);
        check_hex("hex4", r.hex4, hex4);
        check_hex("hex3", exp_letters[27:21], hex3);
        check_hex("hex2", exp_letters[20:14], hex2);
        check_hex("hex1", exp_letters[13:7], hex1);
        check_hex("hex0", exp_letters[6:0], hex0);
        check_flag("motor_left_rev", rev_for_command(exp_drive, 1'b1), motor_left_rev);
        check_flag("motor_right_rev", rev_for_command(exp_drive, 1'b0), motor_right_rev);
        check_duty(duty_for_command(exp_drive, 1'b1), duty_for_command(exp_drive, 1'b0));
    endtask

    initial begin
        wait (num_records > 0);
        #(num_records * 1000 * CLK_PERIOD_NS);
        stop_with_failure($sformatf("Watchdog: the test timed out with %0d records", num_records));
    end

    initial begin
        seed            = 32'he94c;
        reset           = 1'b1;
        ir_rx           = 1'b1;             // Idle high
        cam_direction   = 3'b000;
        speed           = 2'b00;
        orange_detected = 1'b0;
        load_records();
        repeat (2) next_cycle();
        reset = 1'b0;
        next_cycle();
        check_mode(MODE_IDLE, mode);
        check_track(PAUSE, track_state);
        check_drive(STOP, drive_cmd);
        check_flag("motor_left_rev", 1'b0, motor_left_rev);
        check_flag("motor_right_rev", 1'b0, motor_right_rev);
        check_duty(0, 0);
        foreach (records[i])
            run_record(records[i]);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- bench/car_testdata.txt
# key corrupt cam_dir speed orange | exp_mode exp_track exp_drive exp_hex7 exp_hex4
# All fields hex. A set corrupt flag flips one cmd_inv bit of the frame.
13 0 0 0 0 2 3 0 79 0c
07 0 0 0 0 2 3 1 79 0c
18 0 0 0 0 2 3 8 79 0c
00 0 0 0 0 2 3 6 79 0c
02 0 0 0 0 2 3 5 79 0c
11 0 0 0 0 2 3 7 79 0c
08 0 2 0 1 2 3 1 79 0c
0c 0 1 0 1 2 3 2 79 0c
05 0 2 0 0 2 3 4 79 0c
09 0 0 3 0 2 3 0 79 0c
0f 1 0 3 0 2 3 0 79 0c
0f 0 0 0 0 1 0 0 46 12
0c 0 1 0 0 1 0 1 46 12
0c 0 2 0 1 1 1 2 46 0e
0c 0 3 0 1 1 1 3 46 0e
0c 0 3 1 1 1 1 4 46 0e
0c 0 3 2 1 1 1 5 46 0e
0c 0 3 3 1 1 1 0 46 0e
0c 0 3 2 0 1 0 0 46 12
0c 0 1 2 0 1 0 1 46 12
10 1 1 2 0 1 0 1 46 12
13 0 0 0 0 2 3 0 79 0c
0f 0 2 1 1 1 1 2 46 0e
10 0 2 1 1 0 3 0 79 0c
0f 0 0 0 0 1 0 0 46 12
13 0 0 0 0 2 3 0 79 0c
10 0 0 0 0 0 3 0 79 0c

//--- files.f
+incdir+design
design/remote_pkg.sv
design/drive_pkg.sv
design/ir_nec_receiver.sv
design/mode_controller.sv
design/motor_pwm.sv
design/status_display.sv
design/car_top.sv
bench/car_tb.sv
